//--- k005849_timing.f
rtl/k005849_pkg.sv
rtl/k005849_cpu_regs.sv
rtl/k005849_video_timing.sv
rtl/k005849_sync_irq.sv
rtl/k005849_top.sv
test/k005849_asserts.sv
test/tb_clock_gen.sv
test/tb_k005849.sv

//--- rtl/k005849_cpu_regs.sv
// CPU register file and selects
`timescale 1ns/1ps
`default_nettype none

module k005849_cpu_regs
	import k005849_pkg::*;
(
	input  wire                CK49,
	input  wire                arst_n,
	input  wire                xcs,
	input  wire                read,
	input  wire                buse,
	input  wire [ADDR_W-1:0]   a,
	input  wire [DATA_W-1:0]   dbi,
	output logic [DATA_W-1:0]  dbo,
	output logic               iocs,
	output logic               cs80,
	output logic               hmask_en,
	output logic               nmi_en,
	output logic               irq_en,
	output logic               firq_en
);

	// Five control registers, the last one write-only
	logic [DATA_W-1:0] regs [REG_COUNT];

	logic       reg_blk;
	logic [2:0] reg_ofs;
	logic       reg_wr;
	logic       reg_rd;

	// ====================
	// Address decode
	// ====================

	// The block is matched on the page bits and on bits 7..3 of the base
	// Bits 11..8 are not decoded, so the block mirrors through the page
	assign reg_blk = ~xcs && (a[13:12] == REG_PAGE) && (a[7:3] == REG_BASE[7:3]);
	assign reg_ofs = a[2:0];

	// The bus strobe is inverted: read high means the CPU is writing
	assign reg_wr = reg_blk && read && (reg_ofs < REG_COUNT);
	assign reg_rd = reg_blk && (reg_ofs < REG_READABLE);

	// External I/O decoder enable, active low
	assign iocs = ~(~xcs && (a[13:12] == IO_PAGE));

	// Companion chip select just mirrors our own select
	assign cs80 = xcs;

	// ====================
	// Register file
	// ====================

	always_ff @(posedge CK49 or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (reg_wr) begin
			regs[reg_ofs] <= dbi;
		end
	end

	// Bank, priority, scroll direction and flip bits are kept but unused
	assign hmask_en = regs[REG_CTRL][BIT_HMASK];
	assign nmi_en = regs[REG_INT][BIT_NMI_EN];
	assign irq_en = regs[REG_INT][BIT_IRQ_EN];
	assign firq_en = regs[REG_INT][BIT_FIRQ_EN];

	// ====================
	// Read-back
	// ====================

	// Bus released or nothing selected reads as all ones
	always_comb begin
		if (buse) begin
			dbo = '1;
		end else if (reg_rd) begin
			dbo = regs[reg_ofs];
		end else begin
			dbo = '1;
		end
	end

endmodule

`default_nettype wire

//--- rtl/k005849_pkg.sv
// Video timing chip definitions
`default_nettype none

package k005849_pkg;

	// ====================
	// CPU bus
	// ====================

	localparam int ADDR_W = 14;
	localparam int DATA_W = 8;

	// Address bits 13..12 pick the register page or the external I/O decoder
	localparam logic [1:0] REG_PAGE = 2'd2;
	localparam logic [1:0] IO_PAGE = 2'd3;

	// Register block sits at 0x2040, eight offsets wide
	localparam logic [ADDR_W-1:0] REG_BASE = 14'h2040;
	localparam logic [2:0] REG_COUNT = 3'd5;
	localparam logic [2:0] REG_READABLE = 3'd4;

	// Register offsets that carry live control bits
	localparam logic [2:0] REG_CTRL = 3'd3;
	localparam logic [2:0] REG_INT = 3'd4;

	// Bit positions inside those registers
	localparam logic [2:0] BIT_HMASK = 3'd7;
	localparam logic [2:0] BIT_NMI_EN = 3'd0;
	localparam logic [2:0] BIT_IRQ_EN = 3'd1;
	localparam logic [2:0] BIT_FIRQ_EN = 3'd2;

	// ====================
	// Raster
	// ====================

	localparam int CNT_W = 9;

	localparam logic [CNT_W-1:0] H_TOTAL = 9'd384;
	localparam logic [CNT_W-1:0] H_LAST = H_TOTAL - 9'd1;
	localparam logic [CNT_W-1:0] V_LAST = 9'd263;

	// Horizontal blank points, in pixels
	localparam logic [CNT_W-1:0] H_MASK_ON = 9'd5;
	localparam logic [CNT_W-1:0] H_MASK_OFF = 9'd13;
	localparam logic [CNT_W-1:0] H_ACTIVE_END = 9'd253;
	localparam logic [CNT_W-1:0] H_BLANK_START = 9'd261;

	// Vertical blank points, in lines
	localparam logic [CNT_W-1:0] V_BLANK_END = 9'd15;
	localparam logic [CNT_W-1:0] V_BLANK_START = 9'd239;

	// Sync placement before the centering offsets
	localparam logic [CNT_W-1:0] HSYNC_START = 9'd293;
	localparam logic [CNT_W-1:0] HSYNC_LEN = 9'd32;
	localparam logic [CNT_W-1:0] VSYNC_START = 9'd254;
	localparam logic [CNT_W-1:0] VSYNC_LEN = 9'd8;

endpackage

`default_nettype wire

//--- rtl/k005849_sync_irq.sv
// Sync and interrupt generation
`timescale 1ns/1ps
`default_nettype none

module k005849_sync_irq
	import k005849_pkg::*;
(
	input  wire              CK49,
	input  wire              arst_n,
	input  wire [CNT_W-1:0]  h_cnt,
	input  wire [CNT_W-1:0]  v_cnt,
	input  wire              vblank,
	input  wire              frame_odd,
	input  wire [3:0]        hctr,
	input  wire [3:0]        vctr,
	input  wire              nmi_en,
	input  wire              irq_en,
	input  wire              firq_en,
	output logic             hsyc,
	output logic             vsyc,
	output logic             sync,
	output logic             irq,
	output logic             nmi,
	output logic             firq
);

	logic [CNT_W-1:0] hs_start;
	logic [CNT_W-1:0] vs_start;

	logic vblank_q;
	logic vcnt4_q;
	logic vblank_rise;
	logic vcnt4_fall;

	// ====================
	// Sync
	// ====================

	// Bit 3 of hctr moves the pulse left, otherwise bits 2..0 move it right
	assign hs_start = hctr[3] ? (HSYNC_START - 9'd8 - {6'd0, ~hctr[2:0]})
	                          : (HSYNC_START + {6'd0, hctr[2:0]});

	// Vertical centering only ever pulls the pulse earlier
	assign vs_start = VSYNC_START - {5'd0, vctr};

	assign hsyc = ~((h_cnt >= hs_start) && (h_cnt < hs_start + HSYNC_LEN));
	assign vsyc = ~((v_cnt >= vs_start) && (v_cnt < vs_start + VSYNC_LEN));

	// Composite sync, inverted during the vertical pulse
	assign sync = hsyc ^ vsyc;

	// ====================
	// Interrupts
	// ====================

	// Edge detect stage, registered so each flag moves two cycles after its source
	// Line 0 lies in vertical blank, so the previous blank starts out high
	always_ff @(posedge CK49 or negedge arst_n) begin
		if (!arst_n) begin
			vblank_q <= 1'b1;
			vcnt4_q <= 1'b0;
			vblank_rise <= 1'b0;
			vcnt4_fall <= 1'b0;
		end else begin
			vblank_q <= vblank;
			vcnt4_q <= v_cnt[4];
			vblank_rise <= vblank && !vblank_q;
			vcnt4_fall <= vcnt4_q && !v_cnt[4];
		end
	end

	// Each flag is held inactive by its enable and latches low on its event
	// IRQ fires every vertical blank, NMI every 32 lines,
	// FIRQ on the blanks where the frame parity is odd
	always_ff @(posedge CK49 or negedge arst_n) begin
		if (!arst_n) begin
			irq <= 1'b1;
			nmi <= 1'b1;
			firq <= 1'b1;
		end else begin
			if (!irq_en) begin
				irq <= 1'b1;
			end else if (vblank_rise) begin
				irq <= 1'b0;
			end
			if (!nmi_en) begin
				nmi <= 1'b1;
			end else if (vcnt4_fall) begin
				nmi <= 1'b0;
			end
			if (!firq_en) begin
				firq <= 1'b1;
			end else if (vblank_rise && frame_odd) begin
				firq <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/k005849_top.sv
// Video timing chip top level
`timescale 1ns/1ps
`default_nettype none

module k005849_top
	import k005849_pkg::*;
#(
	parameter int PIX_DIV_LOG2 = 3
)
(
	input  wire               CK49,
	input  wire               arst_n,
	input  wire               xcs,
	input  wire               read,
	input  wire               buse,
	input  wire [ADDR_W-1:0]  a,
	input  wire [DATA_W-1:0]  dbi,
	input  wire [3:0]         hctr,
	input  wire [3:0]         vctr,
	output wire [DATA_W-1:0]  dbo,
	output wire               iocs,
	output wire               cs80,
	output wire               hsyc,
	output wire               vsyc,
	output wire               sync,
	output wire               hblk,
	output wire               vblk,
	output wire               irq,
	output wire               nmi,
	output wire               firq
);

	// Control bits from the register file
	wire hmask_en;
	wire nmi_en;
	wire irq_en;
	wire firq_en;

	// Raster state shared by blanking, sync and interrupts
	wire [CNT_W-1:0] h_cnt;
	wire [CNT_W-1:0] v_cnt;
	wire             frame_odd;

	k005849_cpu_regs u_regs (
		.CK49     (CK49),
		.arst_n   (arst_n),
		.xcs      (xcs),
		.read     (read),
		.buse     (buse),
		.a        (a),
		.dbi      (dbi),
		.dbo      (dbo),
		.iocs     (iocs),
		.cs80     (cs80),
		.hmask_en (hmask_en),
		.nmi_en   (nmi_en),
		.irq_en   (irq_en),
		.firq_en  (firq_en)
	);

	k005849_video_timing #(
		.PIX_DIV_LOG2 (PIX_DIV_LOG2)
	) u_timing (
		.CK49      (CK49),
		.arst_n    (arst_n),
		.hmask_en  (hmask_en),
		.pix_en    (),
		.h_cnt     (h_cnt),
		.v_cnt     (v_cnt),
		.hblank    (hblk),
		.vblank    (vblk),
		.frame_odd (frame_odd)
	);

	k005849_sync_irq u_sync_irq (
		.CK49      (CK49),
		.arst_n    (arst_n),
		.h_cnt     (h_cnt),
		.v_cnt     (v_cnt),
		.vblank    (vblk),
		.frame_odd (frame_odd),
		.hctr      (hctr),
		.vctr      (vctr),
		.nmi_en    (nmi_en),
		.irq_en    (irq_en),
		.firq_en   (firq_en),
		.hsyc      (hsyc),
		.vsyc      (vsyc),
		.sync      (sync),
		.irq       (irq),
		.nmi       (nmi),
		.firq      (firq)
	);

endmodule

`default_nettype wire

//--- rtl/k005849_video_timing.sv
// Pixel enable and raster counters
`timescale 1ns/1ps
`default_nettype none

module k005849_video_timing
	import k005849_pkg::*;
#(
	parameter int PIX_DIV_LOG2 = 3
)
(
	input  wire               CK49,
	input  wire               arst_n,
	input  wire               hmask_en,
	output logic              pix_en,
	output logic [CNT_W-1:0]  h_cnt,
	output logic [CNT_W-1:0]  v_cnt,
	output logic              hblank,
	output logic              vblank,
	output logic              frame_odd
);

	logic [PIX_DIV_LOG2-1:0] div;

	logic h_base;
	logic h_left;
	logic h_right;
	logic h_wrap;

	// ====================
	// Pixel enable
	// ====================

	// Free-running divider off the master clock
	always_ff @(posedge CK49 or negedge arst_n) begin
		if (!arst_n) begin
			div <= '0;
		end else begin
			div <= div + 1'b1;
		end
	end

	// One master cycle in every 2**PIX_DIV_LOG2
	assign pix_en = (div == '0);

	// ====================
	// Raster counters
	// ====================

	assign h_wrap = (h_cnt == H_LAST);

	// Horizontal counter steps each pixel, vertical counter steps each line
	always_ff @(posedge CK49 or negedge arst_n) begin
		if (!arst_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
			frame_odd <= 1'b0;
		end else if (pix_en) begin
			if (h_wrap) begin
				h_cnt <= '0;
				if (v_cnt == V_LAST) begin
					v_cnt <= '0;
				end else begin
					v_cnt <= v_cnt + 1'b1;
				end
				// Parity flips on the same edge that opens vertical blank
				if (v_cnt == V_BLANK_START - 1'b1) begin
					frame_odd <= ~frame_odd;
				end
			end else begin
				h_cnt <= h_cnt + 1'b1;
			end
		end
	end

	// ====================
	// Blanking
	// ====================

	// Base horizontal blank wraps across the end of the line
	assign h_base = (h_cnt >= H_BLANK_START) || (h_cnt < H_MASK_ON);

	// Edge columns hidden by the mask bit, 8 pixels at each side
	assign h_left = (h_cnt >= H_MASK_ON) && (h_cnt < H_MASK_OFF);
	assign h_right = (h_cnt >= H_ACTIVE_END) && (h_cnt < H_BLANK_START);

	assign hblank = h_base || (hmask_en && (h_left || h_right));

	// Vertical blank also wraps, covering the bottom and top border lines
	assign vblank = (v_cnt >= V_BLANK_START) || (v_cnt < V_BLANK_END);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the video timing testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_k005849 \
	-f k005849_timing.f \
	-o sim_k005849

./obj_dir/sim_k005849 | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi

echo "Simulation finished without failures"

//--- test/k005849_asserts.sv
// Sync and interrupt properties
`timescale 1ns/1ps
`default_nettype none

module k005849_asserts (
	input wire CK49,
	input wire arst_n,
	input wire hsyc,
	input wire vsyc,
	input wire sync,
	input wire irq,
	input wire nmi,
	input wire firq,
	input wire irq_en,
	input wire nmi_en,
	input wire firq_en
);

	// A flag only drops on an edge where its enable was already set
	irq_masked: assert property (@(posedge CK49) disable iff (!arst_n)
		$fell(irq) |-> $past(irq_en))
		else $error("irq fell while irq_en was clear");

	nmi_masked: assert property (@(posedge CK49) disable iff (!arst_n)
		$fell(nmi) |-> $past(nmi_en))
		else $error("nmi fell while nmi_en was clear");

	firq_masked: assert property (@(posedge CK49) disable iff (!arst_n)
		$fell(firq) |-> $past(firq_en))
		else $error("firq fell while firq_en was clear");

	// Composite sync is the plain XOR of the two pulses
	sync_xor: assert property (@(posedge CK49) disable iff (!arst_n)
		sync == (hsyc ^ vsyc))
		else $error("sync differs from hsyc xor vsyc");

	// IRQ is latched and only released by clearing its enable
	irq_held: assert property (@(posedge CK49) disable iff (!arst_n)
		$rose(irq) |-> !$past(irq_en))
		else $error("irq released while irq_en was still set");

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic CK49,
	output logic arst_n
);

	// 10 ns period
	initial begin
		CK49 = 1'b0;
		forever #5 CK49 = ~CK49;
	end

	// Reset held for ten clocks, released away from the rising edge
	initial begin
		arst_n = 1'b0;
		repeat (10) @(posedge CK49);
		@(negedge CK49);
		arst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- test/tb_k005849.sv
// Video timing chip testbench
`timescale 1ns/1ps
`default_nettype none

module tb_k005849
	import k005849_pkg::*;
();

	// ====================
	// Timing constants
	// ====================

	localparam int PIX_LOG2 = 3;
	localparam int PIX_CYC = 1 << PIX_LOG2;
	localparam int LINE_CYC = int'(H_TOTAL) * PIX_CYC;
	localparam int FRAME_CYC = (int'(V_LAST) + 1) * LINE_CYC;

	// Without the mask the blank runs from 261 round to 4
	localparam int HBLK_PIX = int'(H_TOTAL) - int'(H_BLANK_START) + int'(H_MASK_ON);
	// With the mask both edge strips touch the base blank, so it is one longer run
	localparam int HBLK_MASK_PIX = int'(H_TOTAL) - int'(H_ACTIVE_END) + int'(H_MASK_OFF);
	localparam int VBLK_LINES = int'(V_LAST) + 1 - int'(V_BLANK_START) + int'(V_BLANK_END);
	localparam int NMI_LINES = 32;

	localparam int TBL_MAX = 32;
	localparam int CYC_LIMIT = 3 * FRAME_CYC + 4 * TBL_MAX;
	localparam logic [31:0] SEED = 32'h3e98_0206;

	localparam logic [DATA_W-1:0] INT_ALL =
		(8'd1 << BIT_NMI_EN) | (8'd1 << BIT_IRQ_EN) | (8'd1 << BIT_FIRQ_EN);
	localparam logic [DATA_W-1:0] INT_NO_NMI = INT_ALL & ~(8'd1 << BIT_NMI_EN);
	localparam logic [DATA_W-1:0] HMASK_ON = 8'd1 << BIT_HMASK;

	// Table operations
	localparam int OP_WR = 0;
	localparam int OP_RD = 1;
	localparam int OP_RD_BUSE = 2;
	localparam int OP_SEL = 3;

	// Level selectors for the edge waits
	localparam int SEL_HBLK = 0;
	localparam int SEL_VBLK = 1;
	localparam int SEL_HSYC = 2;
	localparam int SEL_VSYC = 3;
	localparam int SEL_IRQ = 4;
	localparam int SEL_NMI = 5;

	// ====================
	// DUT and clock
	// ====================

	wire               CK49;
	wire               arst_n;
	logic              xcs;
	logic              read;
	logic              buse;
	logic [ADDR_W-1:0] a;
	logic [DATA_W-1:0] dbi;
	logic [3:0]        hctr;
	logic [3:0]        vctr;
	wire [DATA_W-1:0]  dbo;
	wire               iocs;
	wire               cs80;
	wire               hsyc;
	wire               vsyc;
	wire               sync;
	wire               hblk;
	wire               vblk;
	wire               irq;
	wire               nmi;
	wire               firq;

	int                cyc = 0;
	logic              quiet_on = 1'b0;
	logic [31:0]       rng;

	int                tbl_op [TBL_MAX];
	logic [ADDR_W-1:0] tbl_addr [TBL_MAX];
	logic [DATA_W-1:0] tbl_data [TBL_MAX];
	logic [DATA_W-1:0] tbl_exp [TBL_MAX];
	int                tbl_n = 0;

	tb_clock_gen u_clk (
		.CK49   (CK49),
		.arst_n (arst_n)
	);

	k005849_top #(
		.PIX_DIV_LOG2 (PIX_LOG2)
	) u_dut (
		.CK49 (CK49), .arst_n (arst_n), .xcs (xcs), .read (read), .buse (buse),
		.a (a), .dbi (dbi), .hctr (hctr), .vctr (vctr), .dbo (dbo),
		.iocs (iocs), .cs80 (cs80), .hsyc (hsyc), .vsyc (vsyc), .sync (sync),
		.hblk (hblk), .vblk (vblk), .irq (irq), .nmi (nmi), .firq (firq)
	);

	bind k005849_sync_irq k005849_asserts u_asserts (
		.CK49 (CK49), .arst_n (arst_n), .hsyc (hsyc), .vsyc (vsyc), .sync (sync),
		.irq (irq), .nmi (nmi), .firq (firq),
		.irq_en (irq_en), .nmi_en (nmi_en), .firq_en (firq_en)
	);

	// ====================
	// Checks
	// ====================

	task automatic report_failure();
		$display("STATUS: FAIL");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_data(input string name, input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] exp);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
			report_failure();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s = %b, expected %b", $time, name, got, exp);
			report_failure();
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("FAILED at %0t ns: %s = %0d cycles, expected %0d", $time, name, got, exp);
			report_failure();
		end
	endtask

	// Cycle counter and run limit
	always @(posedge CK49) begin
		cyc <= cyc + 1;
		if (cyc >= CYC_LIMIT) begin
			$display("Timeout: the test did not finish within %0d cycles", CYC_LIMIT);
			report_failure();
		end
	end

	// ====================
	// Helpers
	// ====================

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [ADDR_W-1:0] reg_addr(input int ofs);
		return REG_BASE + ADDR_W'(ofs);
	endfunction

	function automatic logic level_of(input int sel);
		case (sel)
			SEL_HBLK: return hblk;
			SEL_VBLK: return vblk;
			SEL_HSYC: return hsyc;
			SEL_VSYC: return vsyc;
			SEL_IRQ:  return irq;
			SEL_NMI:  return nmi;
			default:  return 1'bx;
		endcase
	endfunction

	// One clock; outputs are sampled on the falling edge before new drives
	task automatic step();
		@(negedge CK49);
		if (quiet_on) begin
			check_bit("irq", irq, 1'b1);
			check_bit("nmi", nmi, 1'b1);
			check_bit("firq", firq, 1'b1);
		end
	endtask

	task automatic wait_level(input int sel, input logic val);
		while (level_of(sel) !== val) begin
			step();
		end
	endtask

	task automatic bus_idle();
		xcs = 1'b1;
		read = 1'b0;
		buse = 1'b0;
		dbi = '0;
	endtask

	// The read line is high for a CPU write
	task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		step();
		xcs = 1'b0;
		read = 1'b1;
		a = addr;
		dbi = data;
		step();
		bus_idle();
	endtask

	task automatic bus_read(input logic [ADDR_W-1:0] addr, input logic use_bus,
		output logic [DATA_W-1:0] data);
		step();
		xcs = 1'b0;
		buse = use_bus;
		a = addr;
		step();
		data = dbo;
		bus_idle();
	endtask

	task automatic check_select(input logic [ADDR_W-1:0] addr, input logic sel_n,
		input logic [1:0] exp);
		step();
		xcs = sel_n;
		a = addr;
		step();
		check_bit("iocs", iocs, exp[1]);
		check_bit("cs80", cs80, exp[0]);
		bus_idle();
	endtask

	task automatic add_entry(input int op, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] data, input logic [DATA_W-1:0] exp);
		tbl_op[tbl_n] = op;
		tbl_addr[tbl_n] = addr;
		tbl_data[tbl_n] = data;
		tbl_exp[tbl_n] = exp;
		tbl_n++;
	endtask

	// Writes use random data, reads expect it back on the four readable offsets
	task automatic build_table();
		logic [DATA_W-1:0] shadow [8];
		logic [ADDR_W-1:0] sa;
		logic              sx;
		for (int ofs = 0; ofs < 5; ofs++) begin
			rng = xorshift(rng);
			shadow[ofs] = rng[7:0];
			add_entry(OP_WR, reg_addr(ofs), rng[7:0], 8'h00);
		end
		for (int ofs = 0; ofs < 8; ofs++) begin
			add_entry(OP_RD, reg_addr(ofs), 8'h00, (ofs < 4) ? shadow[ofs] : 8'hff);
		end
		for (int ofs = 0; ofs < 4; ofs++) begin
			add_entry(OP_RD_BUSE, reg_addr(ofs), 8'h00, 8'hff);
		end
		// Every page with the chip both selected and idle
		for (int k = 0; k < 8; k++) begin
			rng = xorshift(rng);
			sa = rng[ADDR_W-1:0];
			sa[13:12] = 2'(k);
			sx = k[2];
			add_entry(OP_SEL, sa, {7'd0, sx}, {6'd0, !(!sx && sa[13:12] == 2'd3), sx});
		end
		add_entry(OP_WR, reg_addr(REG_CTRL), 8'h00, 8'h00);
		add_entry(OP_WR, reg_addr(REG_INT), 8'h00, 8'h00);
		add_entry(OP_RD, reg_addr(REG_CTRL), 8'h00, 8'h00);
		add_entry(OP_RD, reg_addr(REG_INT), 8'h00, 8'hff);
	endtask

	task automatic apply_entry(input int i);
		logic [DATA_W-1:0] got;
		case (tbl_op[i])
			OP_WR: bus_write(tbl_addr[i], tbl_data[i]);
			OP_RD: begin
				bus_read(tbl_addr[i], 1'b0, got);
				check_data("dbo", got, tbl_exp[i]);
			end
			OP_RD_BUSE: begin
				bus_read(tbl_addr[i], 1'b1, got);
				check_data("dbo", got, tbl_exp[i]);
			end
			default: check_select(tbl_addr[i], tbl_data[i][0], tbl_exp[i][1:0]);
		endcase
	endtask

	// ====================
	// Raster checks
	// ====================

	task automatic check_hblank(input int exp_pix);
		int t0;
		wait_level(SEL_HBLK, 1'b0);
		wait_level(SEL_HBLK, 1'b1);
		t0 = cyc;
		wait_level(SEL_HBLK, 1'b0);
		check_count("hblk high", cyc - t0, exp_pix * PIX_CYC);
		wait_level(SEL_HBLK, 1'b1);
		check_count("hblk period", cyc - t0, LINE_CYC);
	endtask

	// Pulse start is measured from the HBLK rise at pixel 261
	task automatic check_hsync(input int shift);
		int t0;
		hctr = 4'(shift);
		wait_level(SEL_HBLK, 1'b0);
		wait_level(SEL_HBLK, 1'b1);
		t0 = cyc;
		wait_level(SEL_HSYC, 1'b0);
		check_count("hsyc start",
			cyc - t0, (int'(HSYNC_START) - int'(H_BLANK_START) + shift) * PIX_CYC);
		// Early lines sit outside the vertical pulse, so VSYC is high here
		check_bit("sync", sync, 1'b1);
		t0 = cyc;
		wait_level(SEL_HSYC, 1'b1);
		check_count("hsyc low", cyc - t0, int'(HSYNC_LEN) * PIX_CYC);
		check_bit("sync", sync, 1'b0);
	endtask

	// ====================
	// Main sequence
	// ====================

	initial begin
		int t_a;
		int t_b;
		int t_q;
		xcs = 1'b1;
		read = 1'b0;
		buse = 1'b0;
		a = '0;
		dbi = '0;
		hctr = 4'd0;
		vctr = 4'd0;
		rng = SEED;
		build_table();
		while (arst_n !== 1'b1) begin
			step();
		end
		for (int i = 0; i < tbl_n; i++) begin
			apply_entry(i);
		end

		// Line 0 of the first frame, so no interrupt event has passed yet
		bus_write(reg_addr(REG_INT), INT_ALL);
		check_hblank(HBLK_PIX);
		check_hsync(0);
		check_hsync(5);
		hctr = 4'd0;
		bus_write(reg_addr(REG_CTRL), HMASK_ON);
		check_hblank(HBLK_MASK_PIX);
		bus_write(reg_addr(REG_CTRL), 8'h00);

		// NMI is latched, so it is cleared and re-armed between two falls
		wait_level(SEL_NMI, 1'b0);
		t_a = cyc;
		check_bit("firq", firq, 1'b1);
		bus_write(reg_addr(REG_INT), INT_NO_NMI);
		wait_level(SEL_NMI, 1'b1);
		bus_write(reg_addr(REG_INT), INT_ALL);
		wait_level(SEL_NMI, 1'b0);
		check_count("nmi period", cyc - t_a, NMI_LINES * LINE_CYC);

		// First vertical blank after reset raises both IRQ and FIRQ
		wait_level(SEL_VBLK, 1'b0);
		wait_level(SEL_VBLK, 1'b1);
		t_a = cyc;
		wait_level(SEL_IRQ, 1'b0);
		check_count("irq delay", cyc - t_a, 2);
		check_bit("firq", firq, 1'b0);
		bus_write(reg_addr(REG_INT), 8'h00);
		t_b = cyc;
		wait_level(SEL_IRQ, 1'b1);
		check_count("irq release", cyc - t_b, 1);
		check_bit("nmi", nmi, 1'b1);
		check_bit("firq", firq, 1'b1);

		// All masks clear from here for one whole frame
		quiet_on = 1'b1;
		t_q = cyc;
		wait_level(SEL_VSYC, 1'b0);
		t_b = cyc;
		// The vertical pulse opens at pixel 0, where HSYC is still high
		check_bit("hsyc", hsyc, 1'b1);
		check_bit("sync", sync, 1'b1);
		// Both pulses low together cancel in SYNC
		wait_level(SEL_HSYC, 1'b0);
		check_bit("sync", sync, 1'b0);
		wait_level(SEL_VSYC, 1'b1);
		check_count("vsyc low", cyc - t_b, int'(VSYNC_LEN) * LINE_CYC);
		check_bit("sync", sync, 1'b0);
		wait_level(SEL_VBLK, 1'b0);
		check_count("vblk high", cyc - t_a, VBLK_LINES * LINE_CYC);
		wait_level(SEL_VBLK, 1'b1);
		check_count("frame period", cyc - t_a, FRAME_CYC);
		while (cyc < t_q + FRAME_CYC) begin
			step();
		end
		quiet_on = 1'b0;

		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire
